//--- sim.f
logic/cache_geom_pkg.sv
logic/mem_bus_pkg.sv
logic/sync_ram.sv
logic/cache_way.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
verif/mem_model.sv
verif/tb_dcache.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dcache -f sim.f > build.log 2>&1 \
    && ./obj_dir/Vtb_dcache > sim.log 2>&1 \
    || echo "build or run error, Regression failed" >> sim.log
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

//--- verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    // reads issued over all tests
    localparam int N_REQUESTS   = 33;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    cpu_req_t    req;
    logic        req_ready;
    logic        rsp_valid;
    word_t       rsp_data;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic        stall_en;
    int          req_count;
    logic [31:0] last_addr;
    logic [3:0]  last_len;

    int    cycle;
    int    n_tests;
    int    n_checks;
    int    n_errors;
    int    test_errors;
    string cur_test;
    word_t exp_data[$];
    logic  exp_fast[$];
    int    acc_cycle[$];

    dcache_top #(
        .N_SETS (256)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    mem_model mem_i (
        .clk           (clk),
        .rst           (rst),
        .stall_en      (stall_en),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .req_count     (req_count),
        .last_addr     (last_addr),
        .last_len      (last_len)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_eq(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
        n_checks++;
        if (expected !== actual) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     cur_test, what, expected, actual);
            n_errors++;
            test_errors++;
        end
    endtask

    // responses must come back in acceptance order
    always @(negedge clk) begin
        int lat;
        if (rst && rsp_valid) begin
            if (acc_cycle.size() == 0) begin
                $display("%s: response seen with no read outstanding", cur_test);
                n_errors++;
                test_errors++;
            end else begin
                lat = cycle - acc_cycle.pop_front();
                check_eq("data", exp_data.pop_front(), rsp_data);
                if (exp_fast.pop_front()) begin
                    check_eq("latency", 32'd1, 32'(lat));
                end
            end
        end
    end

    // word aligned addresses read back as ~addr
    task automatic send_read(input logic [31:0] addr, input logic cached, input logic fast);
        @(negedge clk);
        req_valid  = 1'b1;
        req.addr   = addr;
        req.cached = cached;
        while (!req_ready) begin
            @(negedge clk);
        end
        exp_data.push_back(~addr);
        exp_fast.push_back(fast);
        acc_cycle.push_back(cycle);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        req_valid = 1'b0;
        while (acc_cycle.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        n_tests++;
    endtask

    task automatic end_test();
        $display("%s: done, %0d errors", cur_test, test_errors);
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        check_eq("req_ready", 32'd1, 32'(req_ready));
        check_eq("rsp_valid", 32'd0, 32'(rsp_valid));
        check_eq("mem_req_valid", 32'd0, 32'(mem_req_valid));
        end_test();
    endtask

    task automatic test_miss_then_hit();
        int base_count;
        start_test("miss_then_hit");
        base_count = req_count;
        send_read(32'h0000_104C, 1'b1, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 1, req_count);
        check_eq("request addr", 32'h0000_1040, last_addr);
        check_eq("request len", 32'd15, 32'(last_len));
        send_read(32'h0000_1078, 1'b1, 1'b1);
        wait_idle();
        check_eq("request count", base_count + 1, req_count);
        end_test();
    endtask

    task automatic test_streamed_hits();
        int base_count;
        start_test("streamed_hits");
        base_count = req_count;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            send_read(32'h0000_1040 + 32'(i * 4), 1'b1, 1'b1);
        end
        wait_idle();
        check_eq("request count", base_count, req_count);
        end_test();
    endtask

    // A, B, C share set 0x82 with tags 0, 1, 2
    task automatic test_lru();
        int base_count;
        start_test("lru_replacement");
        base_count = req_count;
        send_read(32'h0000_2080, 1'b1, 1'b0);
        send_read(32'h0000_6080, 1'b1, 1'b0);
        send_read(32'h0000_2080, 1'b1, 1'b1);
        send_read(32'h0000_A080, 1'b1, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 3, req_count);
        // C took B's way and A survives
        send_read(32'h0000_2084, 1'b1, 1'b1);
        wait_idle();
        check_eq("request count", base_count + 3, req_count);
        send_read(32'h0000_6088, 1'b1, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 4, req_count);
        end_test();
    endtask

    task automatic test_uncached();
        int base_count;
        start_test("uncached");
        base_count = req_count;
        send_read(32'h0000_7004, 1'b0, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 1, req_count);
        check_eq("request addr", 32'h0000_7004, last_addr);
        check_eq("request len", 32'd0, 32'(last_len));
        send_read(32'h0000_7004, 1'b0, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 2, req_count);
        end_test();
    endtask

    // D and E share set 0x43
    // two line fills and two uncached reads
    task automatic test_back_pressure();
        int base_count;
        start_test("back_pressure");
        stall_en   = 1'b1;
        base_count = req_count;
        send_read(32'h0000_50C8, 1'b1, 1'b0);
        send_read(32'h0000_50E0, 1'b1, 1'b1);
        send_read(32'h0000_7008, 1'b0, 1'b0);
        send_read(32'h0000_90C4, 1'b1, 1'b0);
        send_read(32'h0000_50FC, 1'b1, 1'b1);
        send_read(32'h0000_90D0, 1'b1, 1'b1);
        send_read(32'h0000_700C, 1'b0, 1'b0);
        wait_idle();
        check_eq("request count", base_count + 4, req_count);
        stall_en = 1'b0;
        end_test();
    endtask

    initial begin
        #((RESET_CYCLES + N_REQUESTS * 40) * CLK_PERIOD);
        $display("timeout: test %s did not finish in time", cur_test);
        $display("Regression failed");
        $finish;
    end

    initial begin
        rst       = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        stall_en  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        test_reset_state();
        test_miss_then_hit();
        test_streamed_hits();
        test_lru();
        test_uncached();
        test_back_pressure();
        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   stall_en,
    input  wire logic                   mem_req_valid,
    input  wire mem_bus_pkg::mem_req_t  mem_req,
    output logic                        mem_req_ready,
    output logic                        mem_rsp_valid,
    output mem_bus_pkg::mem_rsp_t       mem_rsp,
    output int                          req_count,
    output logic [31:0]                 last_addr,
    output logic [3:0]                  last_len
);
    import mem_bus_pkg::*;

    logic                   busy;
    logic [31:0]            base;
    logic [BURST_LEN_W-1:0] len;
    logic [BURST_LEN_W-1:0] beat;
    logic [15:0]            lfsr;

    // galois form, taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic stall();
        if (!stall_en) begin
            return 1'b0;
        end
        return lfsr_bit();
    endfunction

    always @(posedge clk) begin
        if (!rst) begin
            busy      <= 1'b0;
            req_count <= 0;
        end else if (!busy && mem_req_valid && mem_req_ready) begin
            busy      <= 1'b1;
            base      <= mem_req.addr;
            len       <= mem_req.len;
            beat      <= '0;
            req_count <= req_count + 1;
            last_addr <= mem_req.addr;
            last_len  <= mem_req.len;
        end else if (busy && mem_rsp_valid) begin
            beat <= beat + 4'd1;
            if (beat == len) begin
                busy <= 1'b0;
            end
        end
    end

    // outputs change on the falling edge only
    initial begin
        lfsr          = 16'd22;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        forever begin
            @(negedge clk);
            mem_req_ready = 1'b0;
            mem_rsp_valid = 1'b0;
            if (!busy) begin
                mem_req_ready = !stall();
            end else begin
                mem_rsp_valid = !stall();
            end
            // each word reads back as its inverted byte address
            mem_rsp.data = ~(base + {26'd0, beat, 2'b00});
            mem_rsp.last = (beat == len);
        end
    end

endmodule

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int N_SETS = 256
) (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      req_valid,
    input  wire cache_geom_pkg::cpu_req_t  req,
    output logic                           req_ready,
    output logic                           rsp_valid,
    output cache_geom_pkg::word_t          rsp_data,
    output logic                           mem_req_valid,
    output mem_bus_pkg::mem_req_t          mem_req,
    input  wire logic                      mem_req_ready,
    input  wire logic                      mem_rsp_valid,
    input  wire mem_bus_pkg::mem_rsp_t     mem_rsp
);
    import cache_geom_pkg::*;

    logic [1:0]  way_hit;
    word_t [1:0] way_data;
    logic        lookup_en;
    line_addr_t  lookup_addr;
    logic [1:0]  fill_en;
    index_t      fill_index;
    offset_t     fill_offset;
    word_t       fill_data;
    logic        fill_tag_we;

    cache_way #(
        .N_SETS (N_SETS)
    ) way0_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en[0]),
        .fill_index  (fill_index),
        .fill_offset (fill_offset),
        .fill_data   (fill_data),
        .fill_tag_we (fill_tag_we),
        .hit         (way_hit[0]),
        .data        (way_data[0])
    );

    cache_way #(
        .N_SETS (N_SETS)
    ) way1_i (
        .clk         (clk),
        .rst         (rst),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en[1]),
        .fill_index  (fill_index),
        .fill_offset (fill_offset),
        .fill_data   (fill_data),
        .fill_tag_we (fill_tag_we),
        .hit         (way_hit[1]),
        .data        (way_data[1])
    );

    cache_ctrl #(
        .N_SETS (N_SETS)
    ) ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .way_hit       (way_hit),
        .way_data      (way_data),
        .lookup_en     (lookup_en),
        .lookup_addr   (lookup_addr),
        .fill_en       (fill_en),
        .fill_index    (fill_index),
        .fill_offset   (fill_offset),
        .fill_data     (fill_data),
        .fill_tag_we   (fill_tag_we),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
    parameter int N_SETS = 256
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic                         req_valid,
    input  wire cache_geom_pkg::cpu_req_t     req,
    output logic                              req_ready,
    output logic                              rsp_valid,
    output cache_geom_pkg::word_t             rsp_data,
    input  wire logic [1:0]                   way_hit,
    input  wire cache_geom_pkg::word_t [1:0]  way_data,
    output logic                              lookup_en,
    output cache_geom_pkg::line_addr_t        lookup_addr,
    output logic [1:0]                        fill_en,
    output cache_geom_pkg::index_t            fill_index,
    output cache_geom_pkg::offset_t           fill_offset,
    output cache_geom_pkg::word_t             fill_data,
    output logic                              fill_tag_we,
    output logic                              mem_req_valid,
    output mem_bus_pkg::mem_req_t             mem_req,
    input  wire logic                         mem_req_ready,
    input  wire logic                         mem_rsp_valid,
    input  wire mem_bus_pkg::mem_rsp_t        mem_rsp
);
    import cache_geom_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_REQ,
        S_REFILL,
        S_UNC_WAIT
    } state_t;

    state_t            state;
    logic              stage_valid;
    cpu_req_t          stage_req;
    line_addr_t        stage_line;
    logic [N_SETS-1:0] lru;
    way_sel_t          victim;
    way_sel_t          hit_way;
    offset_t           beat_cnt;
    word_t             held_word;
    logic              rsp_from_mem;
    logic              lookup_hit;
    logic              stage_miss;
    logic              accept;
    mem_req_t          mem_req_q;

    assign stage_line = line_addr_t'(stage_req.addr[31:2]);

    // uncached requests leave the lookup stage like a miss
    assign lookup_hit = stage_valid && stage_req.cached && (|way_hit);
    assign stage_miss = stage_valid && !lookup_hit;
    assign req_ready  = (state == S_LOOKUP) && !stage_miss;
    assign accept     = req_valid && req_ready;
    assign hit_way    = way_hit[1] ? WAY1 : WAY0;

    assign lookup_en   = accept && req.cached;
    assign lookup_addr = (state == S_LOOKUP) ? line_addr_t'(req.addr[31:2]) : stage_line;

    assign rsp_valid = lookup_hit || rsp_from_mem;
    assign rsp_data  = rsp_from_mem ? held_word : way_data[hit_way];

    // fill bundle shared, enable per way
    assign fill_index  = stage_line.index;
    assign fill_offset = beat_cnt;
    assign fill_data   = mem_rsp.data;
    assign fill_tag_we = mem_rsp.last;
    assign fill_en[0]  = (state == S_REFILL) && mem_rsp_valid && (victim == WAY0);
    assign fill_en[1]  = (state == S_REFILL) && mem_rsp_valid && (victim == WAY1);

    assign mem_req_valid = (state == S_REQ);
    assign mem_req       = mem_req_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state        <= S_LOOKUP;
            stage_valid  <= 1'b0;
            lru          <= '0;
            beat_cnt     <= '0;
            rsp_from_mem <= 1'b0;
        end else begin
            stage_valid  <= accept;
            rsp_from_mem <= 1'b0;
            case (state)
                S_LOOKUP: begin
                    if (lookup_hit) begin
                        // point at the way that did not hit
                        lru[stage_line.index] <= (hit_way == WAY0);
                    end else if (stage_miss) begin
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mem_req_ready) begin
                        state    <= stage_req.cached ? S_REFILL : S_UNC_WAIT;
                        beat_cnt <= '0;
                    end
                end
                S_REFILL: begin
                    if (mem_rsp_valid) begin
                        beat_cnt <= beat_cnt + offset_t'(1);
                        if (mem_rsp.last) begin
                            lru[stage_line.index] <= (victim == WAY0);
                            rsp_from_mem          <= 1'b1;
                            state                 <= S_LOOKUP;
                        end
                    end
                end
                S_UNC_WAIT: begin
                    if (mem_rsp_valid && mem_rsp.last) begin
                        rsp_from_mem <= 1'b1;
                        state        <= S_LOOKUP;
                    end
                end
                default: begin
                    state <= S_LOOKUP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            stage_req <= req;
        end
        if ((state == S_LOOKUP) && stage_miss) begin
            victim <= way_sel_t'(lru[stage_line.index]);
            if (stage_req.cached) begin
                mem_req_q <= '{addr: {stage_line.tag, stage_line.index, {(OFFSET_W + 2){1'b0}}},
                               len:  LINE_BURST_LEN};
            end else begin
                mem_req_q <= '{addr: {stage_req.addr[31:2], 2'b00}, len: SINGLE_LEN};
            end
        end
        // keep the requested word as it streams past
        if (mem_rsp_valid && ((state == S_UNC_WAIT) ||
            ((state == S_REFILL) && (beat_cnt == stage_line.offset)))) begin
            held_word <= mem_rsp.data;
        end
    end

    a_one_way_hits: assert property (
        @(posedge clk) disable iff (!rst)
        (stage_valid && stage_req.cached) |-> !(&way_hit)
    );

    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req))
    );

endmodule

`default_nettype wire

//--- logic/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way #(
    parameter int N_SETS = 256
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        lookup_en,
    input  wire cache_geom_pkg::line_addr_t  lookup_addr,
    input  wire logic                        fill_en,
    input  wire cache_geom_pkg::index_t      fill_index,
    input  wire cache_geom_pkg::offset_t     fill_offset,
    input  wire cache_geom_pkg::word_t       fill_data,
    input  wire logic                        fill_tag_we,
    output logic                             hit,
    output cache_geom_pkg::word_t            data
);
    import cache_geom_pkg::*;

    localparam int DATA_DEPTH = N_SETS * WORDS_PER_LINE;

    logic [N_SETS-1:0]             valid;
    tag_t                          tag_q;
    index_t                        index_q;
    tag_t                          tag_rdata;
    logic                          tag_we;
    logic                          tag_en;
    index_t                        tag_addr;
    logic                          data_en;
    logic [INDEX_W+OFFSET_W-1:0]   data_addr;

    assign tag_we   = fill_en && fill_tag_we;
    assign tag_en   = lookup_en || tag_we;
    assign tag_addr = fill_en ? fill_index : lookup_addr.index;

    assign data_en   = lookup_en || fill_en;
    assign data_addr = fill_en ? {fill_index, fill_offset}
                               : {lookup_addr.index, lookup_addr.offset};

    // controller parks the missed address on lookup_addr during refill
    sync_ram #(
        .entry_t (tag_t),
        .DEPTH   (N_SETS)
    ) tag_ram_i (
        .clk   (clk),
        .en    (tag_en),
        .we    (tag_we),
        .addr  (tag_addr),
        .wdata (lookup_addr.tag),
        .rdata (tag_rdata)
    );

    sync_ram #(
        .entry_t (word_t),
        .DEPTH   (DATA_DEPTH)
    ) data_ram_i (
        .clk   (clk),
        .en    (data_en),
        .we    (fill_en),
        .addr  (data_addr),
        .wdata (fill_data),
        .rdata (data)
    );

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid <= '0;
        end else if (tag_we) begin
            valid[fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            tag_q   <= lookup_addr.tag;
            index_q <= lookup_addr.index;
        end
    end

    // compare against tag ram output one cycle on
    assign hit = valid[index_q] && (tag_rdata == tag_q);

    a_no_lookup_during_fill: assert property (
        @(posedge clk) disable iff (!rst) !(lookup_en && fill_en)
    );

endmodule

`default_nettype wire

//--- logic/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  wire logic                     clk,
    input  wire logic                     en,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr,
    input  wire entry_t                   wdata,
    output entry_t                        rdata
);

    entry_t mem [DEPTH];

    // read-first, output held while idle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- logic/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    localparam int BURST_LEN_W = 4;

    // beats minus one
    localparam logic [BURST_LEN_W-1:0] LINE_BURST_LEN = 4'd15;
    localparam logic [BURST_LEN_W-1:0] SINGLE_LEN     = 4'd0;

    // word aligned, held until ready
    typedef struct packed {
        logic [31:0]            addr;
        logic [BURST_LEN_W-1:0] len;
    } mem_req_t;

    // beats arrive in rising word order
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- logic/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

    // address split: tag 31:14, index 13:6, word 5:2
    localparam int TAG_W          = 18;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int WORDS_PER_LINE = 1 << OFFSET_W;

    typedef logic [31:0]         word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // word address, byte bits stay in cpu_req_t
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } line_addr_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        cached;
    } cpu_req_t;

    // lru bit of a set names the next victim
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_sel_t;

endpackage

`default_nettype wire
